/* hdl/csr_pkg.sv */
// shared encodings for the machine-mode CSR and trap unit
package csr_pkg;

    // machine-mode CSR addresses
    localparam logic [11:0] addr_mstatus = 12'h300;
    localparam logic [11:0] addr_mtvec   = 12'h305;
    localparam logic [11:0] addr_mepc    = 12'h341;
    localparam logic [11:0] addr_mcause  = 12'h342;

    // SYSTEM major opcode
    localparam logic [6:0] op_system = 7'h73;

    // funct3 of the SYSTEM opcode
    // bit 2 picks the immediate forms
    localparam logic [2:0] f3_priv   = 3'b000;
    localparam logic [2:0] f3_csrrw  = 3'b001;
    localparam logic [2:0] f3_csrrs  = 3'b010;
    localparam logic [2:0] f3_csrrc  = 3'b011;
    localparam logic [2:0] f3_csrrwi = 3'b101;
    localparam logic [2:0] f3_csrrsi = 3'b110;
    localparam logic [2:0] f3_csrrci = 3'b111;

    // funct12 of the privileged forms (rs1 and rd are zero)
    localparam logic [11:0] funct12_ecall  = 12'h000;
    localparam logic [11:0] funct12_ebreak = 12'h001;
    localparam logic [11:0] funct12_mret   = 12'h302;

    // exception codes, zero-extended into mcause
    localparam logic [3:0] cause_illegal    = 4'd2;
    localparam logic [3:0] cause_breakpoint = 4'd3;
    localparam logic [3:0] cause_ecall_m    = 4'd11;

    // mstatus fields in use
    localparam int mie_bit  = 3;
    localparam int mpie_bit = 7;

    // mstatus after reset
    // MPP = 3, plus UXL and SXL on RV64
    localparam logic [63:0] mstatus_rst64 = 64'h0000_000A_0000_1800;
    localparam logic [31:0] mstatus_rst32 = 32'h0000_1800;

    // kind of CSR access
    typedef enum logic [1:0] {
        op_none,
        op_write,
        op_set,
        op_clear
    } csr_op_e;

endpackage

/* hdl/csr_req_if.sv */
`timescale 1ns/100ps

// decoded CSR access from the decoder to the register file
interface csr_req_if #(
    parameter int XLEN = 64
);

    logic [11:0]       addr;
    csr_pkg::csr_op_e  op;
    // rs1 data or zero-extended uimm
    logic [XLEN-1:0]   wdata;
    logic              wr_en;
    logic              rd_en;

    modport dec (
        output addr,
        output op,
        output wdata,
        output wr_en,
        output rd_en
    );

    modport rf (
        input addr,
        input op,
        input wdata,
        input wr_en,
        input rd_en
    );

endinterface

/* hdl/csr_decode.sv */
`timescale 1ns/100ps

module csr_decode #(
    parameter int XLEN = 64
) (
    input  logic             valid_i,
    input  logic [31:0]      instr_i,
    input  logic [XLEN-1:0]  rs1_data_i,
    csr_req_if.dec           req,
    output logic             is_ecall_o,
    output logic             is_ebreak_o,
    output logic             is_mret_o,
    output logic             is_illegal_o
);

    // instruction fields
    logic [6:0]  opcode;
    logic [4:0]  rd_f;
    logic [2:0]  funct3;
    logic [4:0]  rs1_f;
    logic [11:0] funct12;

    logic              is_sys;
    logic              is_priv;
    logic              csr_valid;
    logic              addr_known;
    csr_pkg::csr_op_e  op_raw;

    assign opcode  = instr_i[6:0];
    assign rd_f    = instr_i[11:7];
    assign funct3  = instr_i[14:12];
    assign rs1_f   = instr_i[19:15];
    assign funct12 = instr_i[31:20];

    assign is_sys = valid_i && (opcode == csr_pkg::op_system);

    // funct3 to access kind, op_none for anything that is not a CSR form
    always_comb begin
        case (funct3)
            csr_pkg::f3_csrrw,
            csr_pkg::f3_csrrwi: op_raw = csr_pkg::op_write;
            csr_pkg::f3_csrrs,
            csr_pkg::f3_csrrsi: op_raw = csr_pkg::op_set;
            csr_pkg::f3_csrrc,
            csr_pkg::f3_csrrci: op_raw = csr_pkg::op_clear;
            default:            op_raw = csr_pkg::op_none;
        endcase
    end

    assign csr_valid = is_sys && (op_raw != csr_pkg::op_none);

    // only the four implemented CSRs
    assign addr_known = (funct12 == csr_pkg::addr_mstatus) ||
                        (funct12 == csr_pkg::addr_mtvec)   ||
                        (funct12 == csr_pkg::addr_mepc)    ||
                        (funct12 == csr_pkg::addr_mcause);

    assign req.addr  = funct12;
    assign req.rd_en = csr_valid && addr_known;
    assign req.op    = req.rd_en ? op_raw : csr_pkg::op_none;

    // immediate forms carry a 5-bit uimm in the rs1 field
    assign req.wdata = funct3[2] ? {{(XLEN-5){1'b0}}, rs1_f} : rs1_data_i;

    // set/clear with x0 or a zero uimm only reads
    assign req.wr_en = req.rd_en &&
                       ((op_raw == csr_pkg::op_write) || (rs1_f != 5'd0));

    assign is_illegal_o = csr_valid && !addr_known;

    // privileged forms have rs1 and rd at zero
    assign is_priv = is_sys && (funct3 == csr_pkg::f3_priv) &&
                     (rs1_f == 5'd0) && (rd_f == 5'd0);

    assign is_ecall_o  = is_priv && (funct12 == csr_pkg::funct12_ecall);
    assign is_ebreak_o = is_priv && (funct12 == csr_pkg::funct12_ebreak);
    assign is_mret_o   = is_priv && (funct12 == csr_pkg::funct12_mret);

endmodule

/* hdl/csr_regfile.sv */
`timescale 1ns/100ps

module csr_regfile #(
    parameter int XLEN = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    csr_req_if.rf            req,
    input  logic             trap_i,
    input  logic             mret_i,
    input  logic [XLEN-1:0]  cause_i,
    input  logic [XLEN-1:0]  trap_pc_i,
    output logic [XLEN-1:0]  rdata_o,
    output logic [XLEN-1:0]  mtvec_o,
    output logic [XLEN-1:0]  mepc_o,
    output logic             mie_o
);

    // mstatus reset constant for this XLEN
    localparam logic [63:0] rst_sel = (XLEN == 64) ? csr_pkg::mstatus_rst64 :
                                      {32'h0, csr_pkg::mstatus_rst32};
    localparam logic [XLEN-1:0] mstatus_rst = rst_sel[XLEN-1:0];

    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mcause_q;
    logic            mie_q;
    logic            mpie_q;

    logic [XLEN-1:0] mstatus_val;
    logic [XLEN-1:0] new_val;

    logic hit_mstatus;
    logic hit_mtvec;
    logic hit_mepc;
    logic hit_mcause;

    assign hit_mstatus = (req.addr == csr_pkg::addr_mstatus);
    assign hit_mtvec   = (req.addr == csr_pkg::addr_mtvec);
    assign hit_mepc    = (req.addr == csr_pkg::addr_mepc);
    assign hit_mcause  = (req.addr == csr_pkg::addr_mcause);

    // only MIE and MPIE are live, the rest stays at reset value
    always_comb begin
        mstatus_val = mstatus_rst;
        mstatus_val[csr_pkg::mie_bit]  = mie_q;
        mstatus_val[csr_pkg::mpie_bit] = mpie_q;
    end

    // and-or read mux, quiet when nothing is read
    assign rdata_o = ({XLEN{req.rd_en & hit_mstatus}} & mstatus_val) |
                     ({XLEN{req.rd_en & hit_mtvec}}   & mtvec_q)     |
                     ({XLEN{req.rd_en & hit_mepc}}    & mepc_q)      |
                     ({XLEN{req.rd_en & hit_mcause}}  & mcause_q);

    // read-modify-write on the old value
    always_comb begin
        case (req.op)
            csr_pkg::op_write: new_val = req.wdata;
            csr_pkg::op_set:   new_val = rdata_o | req.wdata;
            csr_pkg::op_clear: new_val = rdata_o & ~req.wdata;
            default:           new_val = rdata_o;
        endcase
    end

    // mepc, low two bits always zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc_q <= '0;
        end else if (trap_i) begin
            mepc_q <= {trap_pc_i[XLEN-1:2], 2'b00};
        end else if (req.wr_en && hit_mepc) begin
            mepc_q <= {new_val[XLEN-1:2], 2'b00};
        end
    end

    // mtvec, direct mode only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_q <= '0;
        end else if (req.wr_en && hit_mtvec) begin
            mtvec_q <= {new_val[XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcause_q <= '0;
        end else if (trap_i) begin
            mcause_q <= cause_i;
        end else if (req.wr_en && hit_mcause) begin
            mcause_q <= new_val;
        end
    end

    // interrupt enable stack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_q  <= 1'b0;
            mpie_q <= 1'b0;
        end else if (trap_i) begin
            mpie_q <= mie_q;
            mie_q  <= 1'b0;
        end else if (mret_i) begin
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
        end else if (req.wr_en && hit_mstatus) begin
            mie_q  <= new_val[csr_pkg::mie_bit];
            mpie_q <= new_val[csr_pkg::mpie_bit];
        end
    end

    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;
    assign mie_o   = mie_q;

endmodule

/* hdl/trap_ctrl.sv */
`timescale 1ns/100ps

module trap_ctrl #(
    parameter int XLEN = 64
) (
    input  logic             is_ecall_i,
    input  logic             is_ebreak_i,
    input  logic             is_mret_i,
    input  logic             is_illegal_i,
    input  logic [XLEN-1:0]  mtvec_i,
    input  logic [XLEN-1:0]  mepc_i,
    output logic             trap_o,
    output logic             mret_o,
    output logic             redirect_valid_o,
    output logic [XLEN-1:0]  cause_o,
    output logic [XLEN-1:0]  redirect_pc_o
);

    logic [3:0] cause_code;

    // flags come in already qualified by valid
    assign trap_o = is_illegal_i | is_ebreak_i | is_ecall_i;

    // a trap wins over a return
    assign mret_o = is_mret_i & ~trap_o;

    // illegal first, then breakpoint, then ecall
    always_comb begin
        if (is_illegal_i) begin
            cause_code = csr_pkg::cause_illegal;
        end else if (is_ebreak_i) begin
            cause_code = csr_pkg::cause_breakpoint;
        end else if (is_ecall_i) begin
            cause_code = csr_pkg::cause_ecall_m;
        end else begin
            cause_code = 4'd0;
        end
    end

    assign cause_o = {{(XLEN-4){1'b0}}, cause_code};

    assign redirect_valid_o = trap_o | mret_o;

    // direct-mode vector base or saved pc
    always_comb begin
        if (trap_o) begin
            redirect_pc_o = {mtvec_i[XLEN-1:2], 2'b00};
        end else if (mret_o) begin
            redirect_pc_o = mepc_i;
        end else begin
            redirect_pc_o = '0;
        end
    end

endmodule

/* hdl/csr_unit_top.sv */
`timescale 1ns/100ps

module csr_unit_top #(
    parameter int XLEN = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             valid_i,
    input  logic [XLEN-1:0]  pc_i,
    input  logic [31:0]      instr_i,
    input  logic [XLEN-1:0]  rs1_data_i,
    output logic [XLEN-1:0]  csr_rdata_o,
    output logic [XLEN-1:0]  redirect_pc_o,
    output logic             redirect_valid_o,
    output logic             mie_o
);

    csr_req_if #(.XLEN(XLEN)) req ();

    logic            is_ecall;
    logic            is_ebreak;
    logic            is_mret;
    logic            is_illegal;
    logic            trap;
    logic            mret;
    logic [XLEN-1:0] cause;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;

    csr_decode #(.XLEN(XLEN)) decode_i (
        .valid_i      (valid_i),
        .instr_i      (instr_i),
        .rs1_data_i   (rs1_data_i),
        .req          (req.dec),
        .is_ecall_o   (is_ecall),
        .is_ebreak_o  (is_ebreak),
        .is_mret_o    (is_mret),
        .is_illegal_o (is_illegal)
    );

    // pc_i is what mepc saves on a trap
    csr_regfile #(.XLEN(XLEN)) regfile_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req.rf),
        .trap_i    (trap),
        .mret_i    (mret),
        .cause_i   (cause),
        .trap_pc_i (pc_i),
        .rdata_o   (csr_rdata_o),
        .mtvec_o   (mtvec),
        .mepc_o    (mepc),
        .mie_o     (mie_o)
    );

    trap_ctrl #(.XLEN(XLEN)) trap_i (
        .is_ecall_i       (is_ecall),
        .is_ebreak_i      (is_ebreak),
        .is_mret_i        (is_mret),
        .is_illegal_i     (is_illegal),
        .mtvec_i          (mtvec),
        .mepc_i           (mepc),
        .trap_o           (trap),
        .mret_o           (mret),
        .redirect_valid_o (redirect_valid_o),
        .cause_o          (cause),
        .redirect_pc_o    (redirect_pc_o)
    );

endmodule

/* tests/tb_clkgen.sv */
`timescale 1ns/100ps

module tb_clkgen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* tests/csr_unit_tb.sv */
`timescale 1ns/100ps

module csr_unit_tb;

    localparam int n_rand = 40;
    // instructions issued over all tests
    localparam int n_instr = 4 + 2 * n_rand + 24 + 13 + 12 + 10;
    // two cycles per instruction plus reset and margin
    localparam int watchdog_ns = (n_instr * 2 + 5 + 50) * 10;

    logic        clk;
    logic        rst_n;
    logic        valid;
    logic [63:0] pc;
    logic [31:0] instr;
    logic [63:0] rs1_data;
    logic [63:0] csr_rdata;
    logic [63:0] redirect_pc;
    logic        redirect_valid;
    logic        mie;

    // outputs sampled once the inputs settle and before the rising edge
    logic [63:0] got_rdata;
    logic [63:0] got_rpc;
    logic        got_rv;
    logic        got_mie;

    // CSR model
    logic [63:0] m_mepc;
    logic [63:0] m_mtvec;
    logic [63:0] m_mcause;
    logic        m_mie;
    logic        m_mpie;

    logic [11:0] csr_addrs [4];
    logic [2:0]  f3_pool [8];
    integer      seed;
    string       cur_test;
    int          test_err;
    int          n_pass;
    int          n_fail;

    tb_clkgen clkgen_i (.clk(clk), .rst_n(rst_n));

    csr_unit_top #(.XLEN(64)) dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .valid_i          (valid),
        .pc_i             (pc),
        .instr_i          (instr),
        .rs1_data_i       (rs1_data),
        .csr_rdata_o      (csr_rdata),
        .redirect_pc_o    (redirect_pc),
        .redirect_valid_o (redirect_valid),
        .mie_o            (mie)
    );

    // a redirect only ever comes with an accepted instruction
    assert property (@(posedge clk) disable iff (!rst_n) redirect_valid |-> valid)
        else begin
            $display("redirect raised without a valid instruction in %s", cur_test);
            test_err++;
        end

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [31:0] csr_instr(input logic [2:0] f3,
                                              input logic [11:0] addr,
                                              input logic [4:0] src_f);
        return {addr, src_f, f3, 5'd1, csr_pkg::op_system};
    endfunction

    function automatic logic [31:0] priv_instr(input logic [11:0] f12);
        return {f12, 5'd0, csr_pkg::f3_priv, 5'd0, csr_pkg::op_system};
    endfunction

    function automatic logic [63:0] model_read(input logic [11:0] addr);
        logic [63:0] v;
        v = 64'd0;
        case (addr)
            csr_pkg::addr_mstatus: begin
                v = csr_pkg::mstatus_rst64;
                v[csr_pkg::mie_bit]  = m_mie;
                v[csr_pkg::mpie_bit] = m_mpie;
            end
            csr_pkg::addr_mtvec:  v = m_mtvec;
            csr_pkg::addr_mepc:   v = m_mepc;
            csr_pkg::addr_mcause: v = m_mcause;
            default:              v = 64'd0;
        endcase
        return v;
    endfunction

    // mepc and mtvec drop bits 1:0
    // mstatus keeps only MIE and MPIE
    task automatic model_write(input logic [11:0] addr, input logic [63:0] v);
        case (addr)
            csr_pkg::addr_mstatus: begin
                m_mie  = v[csr_pkg::mie_bit];
                m_mpie = v[csr_pkg::mpie_bit];
            end
            csr_pkg::addr_mtvec:  m_mtvec  = v & ~64'h3;
            csr_pkg::addr_mepc:   m_mepc   = v & ~64'h3;
            csr_pkg::addr_mcause: m_mcause = v;
            default: ;
        endcase
    endtask

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp)
            else begin
                $display("mismatch %s: %s expected %h actual %h", cur_test, what, exp, act);
                test_err++;
            end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_err = 0;
    endtask

    task automatic end_test();
        if (test_err == 0) begin
            $display("test %s: pass", cur_test);
            n_pass++;
        end else begin
            $display("test %s: fail, %0d errors", cur_test, test_err);
            n_fail++;
        end
    endtask

    // one instruction with valid high for a single cycle
    task automatic issue(input logic [31:0] word, input logic [63:0] src,
                         input logic [63:0] at_pc);
        @(negedge clk);
        valid    = 1'b1;
        instr    = word;
        rs1_data = src;
        pc       = at_pc;
        #2;
        got_rdata = csr_rdata;
        got_rpc   = redirect_pc;
        got_rv    = redirect_valid;
        got_mie   = mie;
        @(negedge clk);
        valid = 1'b0;
    endtask

    task automatic run_csr(input logic [2:0] f3, input logic [11:0] addr,
                           input logic [4:0] src_f, input logic [63:0] src);
        logic [63:0] old;
        logic [63:0] opnd;
        logic [63:0] nxt;
        old  = model_read(addr);
        opnd = f3[2] ? {59'd0, src_f} : src;
        issue(csr_instr(f3, addr, src_f), src, 64'd0);
        check_value("csr read", old, got_rdata);
        check_value("redirect on csr op", 64'd0, {63'd0, got_rv});
        check_value("mie_o", {63'd0, m_mie}, {63'd0, got_mie});
        case (f3)
            csr_pkg::f3_csrrw, csr_pkg::f3_csrrwi: nxt = opnd;
            csr_pkg::f3_csrrs, csr_pkg::f3_csrrsi: nxt = old | opnd;
            default:                               nxt = old & ~opnd;
        endcase
        if (f3 == csr_pkg::f3_csrrw || f3 == csr_pkg::f3_csrrwi || src_f != 5'd0) begin
            model_write(addr, nxt);
        end
    endtask

    task automatic read_all();
        foreach (csr_addrs[i]) begin
            run_csr(csr_pkg::f3_csrrs, csr_addrs[i], 5'd0, 64'd0);
        end
    endtask

    task automatic run_trap(input logic [31:0] word, input logic [63:0] at_pc,
                            input logic [3:0] cause);
        issue(word, rand64(), at_pc);
        check_value("trap redirect valid", 64'd1, {63'd0, got_rv});
        check_value("trap target", m_mtvec & ~64'h3, got_rpc);
        check_value("read data on trap", 64'd0, got_rdata);
        m_mepc   = at_pc & ~64'h3;
        m_mcause = {60'd0, cause};
        m_mpie   = m_mie;
        m_mie    = 1'b0;
    endtask

    task automatic run_mret();
        issue(priv_instr(csr_pkg::funct12_mret), 64'd0, 64'd0);
        check_value("mret redirect valid", 64'd1, {63'd0, got_rv});
        check_value("mret target", m_mepc, got_rpc);
        m_mie  = m_mpie;
        m_mpie = 1'b1;
    endtask

    initial begin
        #(watchdog_ns);
        $display("timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        valid    = 1'b0;
        pc       = 64'd0;
        instr    = 32'd0;
        rs1_data = 64'd0;
        m_mepc   = 64'd0;
        m_mtvec  = 64'd0;
        m_mcause = 64'd0;
        m_mie    = 1'b0;
        m_mpie   = 1'b0;
        seed     = 32'h1f975b0e;
        n_pass   = 0;
        n_fail   = 0;
        csr_addrs = '{csr_pkg::addr_mstatus, csr_pkg::addr_mtvec,
                      csr_pkg::addr_mepc, csr_pkg::addr_mcause};
        f3_pool = '{csr_pkg::f3_csrrw, csr_pkg::f3_csrrs, csr_pkg::f3_csrrc,
                    csr_pkg::f3_csrrwi, csr_pkg::f3_csrrsi, csr_pkg::f3_csrrci,
                    csr_pkg::f3_csrrw, csr_pkg::f3_csrrc};
        start_test("reset state");
        @(posedge rst_n);
        @(negedge clk);
        #2;
        check_value("redirect after reset", 64'd0, {63'd0, redirect_valid});
        check_value("mie_o after reset", 64'd0, {63'd0, mie});
        read_all();
        end_test();

        start_test("read-modify-write");
        repeat (n_rand) begin
            r = $random(seed);
            run_csr(f3_pool[r[4:2]], csr_addrs[r[1:0]], r[9:5], rand64());
            run_csr(csr_pkg::f3_csrrs, csr_addrs[r[1:0]], 5'd0, 64'd0);
        end
        end_test();

        // a zero source field must not write even with nonzero rs1 data
        start_test("zero source");
        foreach (csr_addrs[i]) begin
            run_csr(csr_pkg::f3_csrrw, csr_addrs[i], 5'd7, rand64());
            run_csr(csr_pkg::f3_csrrs, csr_addrs[i], 5'd0, rand64());
            run_csr(csr_pkg::f3_csrrc, csr_addrs[i], 5'd0, rand64());
            run_csr(csr_pkg::f3_csrrsi, csr_addrs[i], 5'd0, rand64());
            run_csr(csr_pkg::f3_csrrci, csr_addrs[i], 5'd0, rand64());
            run_csr(csr_pkg::f3_csrrs, csr_addrs[i], 5'd0, 64'd0);
        end
        end_test();

        start_test("ecall and ebreak");
        run_csr(csr_pkg::f3_csrrw, csr_pkg::addr_mtvec, 5'd2, rand64() | 64'h3);
        run_csr(csr_pkg::f3_csrrsi, csr_pkg::addr_mstatus, 5'd8, 64'd0);
        run_trap(priv_instr(csr_pkg::funct12_ecall), rand64() & ~64'h3,
                 csr_pkg::cause_ecall_m);
        read_all();
        run_csr(csr_pkg::f3_csrrsi, csr_pkg::addr_mstatus, 5'd8, 64'd0);
        run_trap(priv_instr(csr_pkg::funct12_ebreak), rand64() & ~64'h3,
                 csr_pkg::cause_breakpoint);
        read_all();
        end_test();

        start_test("mret");
        run_csr(csr_pkg::f3_csrrw, csr_pkg::addr_mepc, 5'd4, rand64());
        run_mret();
        read_all();
        // clearing MPIE first makes MIE fall on the next return
        run_csr(csr_pkg::f3_csrrc, csr_pkg::addr_mstatus, 5'd5, 64'h80);
        run_mret();
        read_all();
        end_test();

        start_test("illegal address");
        run_trap(csr_instr(csr_pkg::f3_csrrw, 12'h7c0, 5'd3), rand64() & ~64'h3,
                 csr_pkg::cause_illegal);
        read_all();
        run_trap(csr_instr(csr_pkg::f3_csrrsi, 12'h344, 5'd9), rand64() & ~64'h3,
                 csr_pkg::cause_illegal);
        read_all();
        end_test();

        $display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
hdl/csr_pkg.sv
hdl/csr_req_if.sv
hdl/csr_decode.sv
hdl/csr_regfile.sv
hdl/trap_ctrl.sv
hdl/csr_unit_top.sv
tests/tb_clkgen.sv
tests/csr_unit_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with verilator, run it and look for the pass message
rm -rf obj_dir &&
verilator --binary --timing --assert \
    -f flist.f --top-module csr_unit_tb -o csr_unit_sim &&
./obj_dir/csr_unit_sim |
    awk '{ print } /^ALL TESTS PASSED$/ { ok = 1 } END { exit !ok }' &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: build or simulation failed"; exit 1; }
